// File: design/cpuRegPkg.sv
`default_nettype none

package cpuRegPkg;

  localparam int RegRowCnt = 8; // Row 0 is the empty row

  typedef logic [63:0] regDataT;
  typedef logic [31:0] aluDataT;
  typedef logic [5:0] regIdxT;   // Slice code 5..3, row 2..0
  typedef logic [11:0] colRowT;  // R W H L columns, then one-hot row
  typedef logic [1:0] wwT;       // Byte, 16, 32, 64 bit
  typedef logic [$clog2(RegRowCnt)-1:0] rowIdxT;

  // Column patterns, bit 3 is bits 63..32, bit 0 is bits 7..0
  localparam logic [3:0] ColNone   = 4'b0000;
  localparam logic [3:0] ColAll    = 4'b1111;
  localparam logic [3:0] ColHigh32 = 4'b1000;
  localparam logic [3:0] ColLow32  = 4'b0111;
  localparam logic [3:0] ColHigh16 = 4'b0100; // Bits 31..16
  localparam logic [3:0] ColLow16  = 4'b0011;
  localparam logic [3:0] ColHigh8  = 4'b0010; // Bits 15..8
  localparam logic [3:0] ColLow8   = 4'b0001;

  function automatic wwT colWw(logic [3:0] col);
    case (col)
      ColAll: return 2'd3;
      ColHigh32, ColLow32: return 2'd2;
      ColHigh16, ColLow16: return 2'd1;
      default: return 2'd0;
    endcase
  endfunction

  // Sign bit of a value held at the given width
  function automatic logic signAt(aluDataT data, wwT ww);
    case (ww)
      2'd0: return data[7];
      2'd1: return data[15];
      default: return data[31];
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/cpuAluPkg.sv
`default_nettype none

package cpuAluPkg;

  typedef logic [3:0] aluSelT; // One-hot operation selector
  typedef logic [3:0] flagsT;  // VNZC
  typedef logic [3:0] condT;

  localparam int FlagV = 3;
  localparam int FlagN = 2;
  localparam int FlagZ = 1;
  localparam int FlagC = 0;

  // Arithmetic selector bits, or is xor and and together
  localparam int AluAdd = 0;
  localparam int AluSub = 1;
  localparam int AluAnd = 2;
  localparam int AluXor = 3;

  // Shifter selector bits
  localparam int ShfShl = 0;
  localparam int ShfShr = 1;
  localparam int ShfRol = 2;
  localparam int ShfAsr = 3;

  // Bit manipulation selector bits, bit 3 unused
  localparam int BitBt  = 0;
  localparam int BitBtr = 1;
  localparam int BitBts = 2;

endpackage

`default_nettype wire

// File: design/wrBusIf.sv
`timescale 1ns/1ps
`default_nettype none

interface wrBusIf;
  import cpuRegPkg::*;
  import cpuAluPkg::*;

  regDataT aluData;   // Already aligned to its column
  colRowT aluColRow;
  flagsT flagsData;
  logic flagsLoad;

  modport src (output aluData, aluColRow, flagsData, flagsLoad);
  modport dst (input aluData, aluColRow, flagsData, flagsLoad);

endinterface

`default_nettype wire

// File: design/colRowDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module colRowDecoder (
  input wire cpuRegPkg::regIdxT regIdx,
  output cpuRegPkg::colRowT colRow
);
  import cpuRegPkg::*;

  logic [3:0] col;
  logic [7:0] row;

  always_comb begin
    case (regIdx[5:3])
      3'd0: col = ColLow8;
      3'd1: col = ColHigh8;
      3'd2: col = ColLow16;
      3'd3: col = ColHigh16;
      3'd4: col = ColLow32;
      3'd5: col = ColHigh32;
      3'd6: col = ColAll;
      default: col = ColNone; // Slice code 7 selects nothing
    endcase
    row = 8'b1 << regIdx[2:0];
    row[0] = 1'b0; // Row 0 never holds a register
  end

  assign colRow = {col, row};

endmodule

`default_nettype wire

// File: design/regTask.sv
`timescale 1ns/1ps
`default_nettype none

module regTask (
  input wire clkH,
  input wire rstN,
  wrBusIf.dst wrBus,
  input wire cpuRegPkg::colRowT extColRow,
  input wire cpuRegPkg::regDataT extData,
  input wire cpuRegPkg::rowIdxT rdRow,
  output cpuRegPkg::regDataT rows [1:cpuRegPkg::RegRowCnt-1],
  output cpuRegPkg::regDataT rdData,
  output cpuAluPkg::flagsT flags
);
  import cpuRegPkg::*;

  regDataT aluMask;
  regDataT extMask;
  regDataT rowNext [1:RegRowCnt-1];

  function automatic regDataT colMask(input logic [3:0] col);
    return {{32{col[3]}}, {16{col[2]}}, {8{col[1]}}, {8{col[0]}}};
  endfunction

  assign aluMask = colMask(wrBus.aluColRow[11:8]);
  assign extMask = colMask(extColRow[11:8]);

  always_comb begin
    for (int r = 1; r < RegRowCnt; r++) begin
      rowNext[r] = rows[r];
      if (wrBus.aluColRow[r])
        rowNext[r] = (rowNext[r] & ~aluMask) | (wrBus.aluData & aluMask);
      if (extColRow[r]) // External port wins on overlap
        rowNext[r] = (rowNext[r] & ~extMask) | (extData & extMask);
    end
  end

  always_ff @(posedge clkH or negedge rstN) begin
    if (!rstN) begin
      for (int r = 1; r < RegRowCnt; r++) begin
        rows[r] <= '0;
      end
      flags <= '0;
    end else begin
      for (int r = 1; r < RegRowCnt; r++) begin
        rows[r] <= rowNext[r];
      end
      if (wrBus.flagsLoad) begin
        flags <= wrBus.flagsData;
      end
    end
  end

  // Host read of a whole row, row 0 is empty
  always_comb begin
    rdData = '0;
    for (int r = 1; r < RegRowCnt; r++) begin
      if (rdRow == rowIdxT'(r)) rdData = rows[r];
    end
  end

endmodule

`default_nettype wire

// File: design/operandMux.sv
`timescale 1ns/1ps
`default_nettype none

module operandMux (
  input wire cpuRegPkg::regDataT rows [1:cpuRegPkg::RegRowCnt-1],
  input wire cpuRegPkg::colRowT colRow,
  input wire cpuRegPkg::wwT ww,
  input wire signExt,
  input wire constSel,
  input wire cpuRegPkg::aluDataT constData,
  output cpuRegPkg::aluDataT operand
);
  import cpuRegPkg::*;

  regDataT rowData;
  aluDataT aligned;
  aluDataT raw;

  always_comb begin
    rowData = '0;
    for (int r = 1; r < RegRowCnt; r++) begin
      if (colRow[r]) rowData = rowData | rows[r]; // Row select is one-hot
    end
    // Slice down to bit 0
    case (colRow[11:8])
      ColAll, ColLow32: aligned = rowData[31:0];
      ColHigh32: aligned = rowData[63:32];
      ColHigh16: aligned = {16'h0, rowData[31:16]};
      ColLow16:  aligned = {16'h0, rowData[15:0]};
      ColHigh8:  aligned = {24'h0, rowData[15:8]};
      ColLow8:   aligned = {24'h0, rowData[7:0]};
      default:   aligned = '0;
    endcase
  end

  assign raw = constSel ? constData : aligned;

  always_comb begin
    case (ww)
      2'd0: operand = {{24{signExt & raw[7]}}, raw[7:0]};
      2'd1: operand = {{16{signExt & raw[15]}}, raw[15:0]};
      default: operand = raw; // 32 and 64 bit pass as is
    endcase
  end

endmodule

`default_nettype wire

// File: design/aluArith.sv
`timescale 1ns/1ps
`default_nettype none

module aluArith (
  input wire cpuRegPkg::aluDataT dataS,
  input wire cpuRegPkg::aluDataT dataU,
  input wire cpuRegPkg::wwT wwS,
  input wire cpuRegPkg::wwT wwU,
  input wire cpuAluPkg::aluSelT oper,
  input wire [3:0] dstCol,
  output cpuRegPkg::aluDataT result,
  output cpuAluPkg::flagsT flagsData,
  output logic active
);
  import cpuRegPkg::*;
  import cpuAluPkg::*;

  aluDataT dataSA;
  logic [32:0] resAdd;
  logic isSub;
  logic isAddSub;
  logic signS, signU, signR;

  // Sub runs through the adder as U + ~S + 1
  assign isSub = oper[AluSub];
  assign isAddSub = oper[AluAdd] | oper[AluSub];
  assign dataSA = isSub ? ~dataS : dataS;
  assign resAdd = {1'b0, dataU} + {1'b0, dataSA} + 33'(isSub);
  assign active = |oper;

  assign result =
    (isAddSub ? resAdd[31:0] : '0) |
    (oper[AluXor] ? dataS ^ dataU : '0) |
    (oper[AluAnd] ? dataS & dataU : '0); // Both set gives or

  assign signS = signAt(dataSA, wwS);
  assign signU = signAt(dataU, wwU);
  assign signR = signAt(result, colWw(dstCol));

  always_comb begin
    flagsData = '0;
    if (active) begin
      flagsData[FlagV] = isAddSub & ~(signS ^ signU) & (signU ^ signR);
      flagsData[FlagN] = signR;
      flagsData[FlagZ] = (result == '0);
      flagsData[FlagC] = isAddSub & (isSub ^ resAdd[32]); // Borrow on sub
    end
  end

endmodule

`default_nettype wire

// File: design/aluShift.sv
`timescale 1ns/1ps
`default_nettype none

module aluShift (
  input wire [4:0] amount,
  input wire cpuRegPkg::aluDataT dataU,
  input wire cpuAluPkg::aluSelT oper,
  input wire [3:0] dstCol,
  output cpuRegPkg::aluDataT result,
  output cpuAluPkg::flagsT flagsData,
  output logic active
);
  import cpuRegPkg::*;
  import cpuAluPkg::*;

  wwT dstWw;
  logic isRight;
  logic [4:0] rs;
  aluDataT rolLow;
  logic [64:0] word;           // High half, low half, guard bit
  logic [64:0] stage [0:5];
  logic carry, zero;

  assign dstWw = colWw(dstCol);
  assign isRight = oper[ShfShr] | oper[ShfAsr];
  assign active = |oper;
  // Left ops become a right shift by 32 - amount
  assign rs = isRight ? amount : 5'd0 - amount;

  always_comb begin
    case (dstWw)
      2'd0: rolLow = {dataU[7:0], 24'h0};
      2'd1: rolLow = {dataU[15:0], 16'h0};
      default: rolLow = dataU;
    endcase
    word = '0;
    if (oper[ShfShl]) word = {dataU, 33'h0};
    if (oper[ShfRol]) word = {dataU, rolLow, 1'b0};
    if (oper[ShfShr]) word = {32'h0, dataU, 1'b0};
    if (oper[ShfAsr]) word = {{32{dataU[31]}}, dataU, 1'b0};
  end

  assign stage[0] = word;
  for (genvar i = 0; i < 5; i++) begin : gStage
    assign stage[i+1] = rs[i] ? stage[i] >> (1 << i) : stage[i];
  end

  assign result = !active ? '0 : (amount == '0) ? dataU : stage[5][32:1];

  always_comb begin
    case (dstWw)
      2'd0: carry = stage[5][9];
      2'd1: carry = stage[5][17];
      default: carry = stage[5][33];
    endcase
    if (isRight) carry = stage[5][0]; // Guard bit holds the last bit out
    case (dstWw)
      2'd0: zero = (result[7:0] == '0);
      2'd1: zero = (result[15:0] == '0);
      default: zero = (result == '0);
    endcase
    flagsData = '0;
    if (active) begin
      flagsData[FlagN] = signAt(result, dstWw);
      flagsData[FlagZ] = zero;
      flagsData[FlagC] = carry & (amount != '0);
    end
  end

endmodule

`default_nettype wire

// File: design/fastAlu.sv
`timescale 1ns/1ps
`default_nettype none

module fastAlu (
  input wire cpuRegPkg::aluDataT operandS,
  input wire cpuRegPkg::aluDataT operandU,
  input wire cpuRegPkg::wwT wwS,
  input wire cpuRegPkg::wwT wwU,
  input wire cpuAluPkg::aluSelT selA,
  input wire cpuAluPkg::aluSelT selS,
  input wire cpuAluPkg::aluSelT selT,
  input wire cpuRegPkg::colRowT dstColRow,
  input wire flagWr,
  wrBusIf.src wrBus
);
  import cpuRegPkg::*;
  import cpuAluPkg::*;

  aluDataT resA, resS, resT, resAll, bitMask;
  flagsT flagsA, flagsS, flagsB;
  logic activeA, activeS, activeT, anyActive;

  aluArith uAluArith (
    .dataS(operandS), .dataU(operandU), .wwS(wwS), .wwU(wwU), .oper(selA),
    .dstCol(dstColRow[11:8]), .result(resA), .flagsData(flagsA), .active(activeA)
  );

  aluShift uAluShift (
    .amount(operandS[4:0]), .dataU(operandU), .oper(selS), .dstCol(dstColRow[11:8]),
    .result(resS), .flagsData(flagsS), .active(activeS)
  );

  // ********************************************************************
  // Bit manipulation on U, bit index from S
  // ********************************************************************
  assign bitMask = aluDataT'(1) << operandS[4:0];
  assign activeT = |selT;
  assign resT =
    (selT[BitBts] ? operandU | bitMask : '0) |
    (selT[BitBtr] ? operandU & ~bitMask : '0) |
    (selT[BitBt] ? operandU : '0);
  assign flagsB = activeT ? flagsT'(|(operandU & bitMask)) << FlagC : '0; // Old bit into C

  assign resAll = resA | resS | resT;
  assign anyActive = activeA | activeS | activeT;

  always_comb begin
    case (dstColRow[11:8])
      ColAll, ColLow32: wrBus.aluData = {32'h0, resAll};
      ColHigh32: wrBus.aluData = {resAll, 32'h0};
      ColHigh16: wrBus.aluData = {32'h0, resAll[15:0], 16'h0};
      ColLow16:  wrBus.aluData = {48'h0, resAll[15:0]};
      ColHigh8:  wrBus.aluData = {48'h0, resAll[7:0], 8'h0};
      ColLow8:   wrBus.aluData = {56'h0, resAll[7:0]};
      default:   wrBus.aluData = '0;
    endcase
  end

  assign wrBus.aluColRow = anyActive ? dstColRow : '0;
  assign wrBus.flagsData = flagsA | flagsS | flagsB;
  assign wrBus.flagsLoad = flagWr & anyActive;

endmodule

`default_nettype wire

// File: design/condAnalyzer.sv
`timescale 1ns/1ps
`default_nettype none

module condAnalyzer (
  input wire cpuAluPkg::condT cond,
  input wire cpuAluPkg::flagsT flagsIn,
  output logic jmpEn
);
  import cpuAluPkg::*;

  logic smaller;

  assign smaller = flagsIn[FlagN] ^ flagsIn[FlagV]; // Signed less than

  always_comb begin
    case (cond)
      4'h0: jmpEn = 1'b1;
      4'h1: jmpEn = flagsIn[FlagZ] | flagsIn[FlagC];   // Below or equal
      4'h2: jmpEn = flagsIn[FlagC];
      4'h3: jmpEn = ~flagsIn[FlagC];
      4'h4: jmpEn = flagsIn[FlagZ];
      4'h5: jmpEn = ~flagsIn[FlagZ];
      4'h6: jmpEn = ~flagsIn[FlagZ] & ~flagsIn[FlagC]; // Above
      4'h7: jmpEn = 1'b0;
      4'h8: jmpEn = ~flagsIn[FlagZ] & ~smaller;        // Greater
      4'h9: jmpEn = flagsIn[FlagZ] | ~smaller;
      4'hA: jmpEn = smaller;
      4'hB: jmpEn = flagsIn[FlagZ] | smaller;
      4'hC: jmpEn = flagsIn[FlagN];
      4'hD: jmpEn = flagsIn[FlagV];
      4'hE: jmpEn = ~flagsIn[FlagN];
      default: jmpEn = ~flagsIn[FlagV];
    endcase
  end

endmodule

`default_nettype wire

// File: design/execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore (
  input wire clkH,
  input wire rstN,
  input wire opStrobe,
  input wire cpuRegPkg::regIdxT opIdxS,
  input wire cpuRegPkg::regIdxT opIdxU,
  input wire cpuRegPkg::regIdxT opIdxR,
  input wire cpuRegPkg::aluDataT opConst,
  input wire opConstSel,
  input wire opSignExt,
  input wire cpuAluPkg::aluSelT opSelA,
  input wire cpuAluPkg::aluSelT opSelS,
  input wire cpuAluPkg::aluSelT opSelT,
  input wire opFlagWr,
  input wire regWrStrobe,
  input wire cpuRegPkg::regIdxT regWrIdx,
  input wire cpuRegPkg::regDataT regWrData,
  input wire [2:0] regRdRow,
  output cpuRegPkg::regDataT regRdData,
  output cpuAluPkg::flagsT flags,
  input wire cpuAluPkg::condT condCode,
  output logic jmpEn
);
  import cpuRegPkg::*;
  import cpuAluPkg::*;

  // ********************************************************************
  // Micro-op register
  // ********************************************************************
  regIdxT uopIdxS, uopIdxU, uopIdxR;
  aluDataT uopConst;
  logic uopConstSel, uopSignExt, uopFlagWr;
  aluSelT uopSelA, uopSelS, uopSelT;

  always_ff @(posedge clkH or negedge rstN) begin
    if (!rstN) begin
      uopIdxS <= '0;
      uopIdxU <= '0;
      uopIdxR <= '0;
      uopConst <= '0;
      uopConstSel <= 1'b0;
      uopSignExt <= 1'b0;
      uopSelA <= '0;
      uopSelS <= '0;
      uopSelT <= '0;
      uopFlagWr <= 1'b0;
    end else begin
      // No strobe loads a no-op
      uopIdxS <= opStrobe ? opIdxS : '0;
      uopIdxU <= opStrobe ? opIdxU : '0;
      uopIdxR <= opStrobe ? opIdxR : '0;
      uopConst <= opStrobe ? opConst : '0;
      uopConstSel <= opStrobe & opConstSel;
      uopSignExt <= opStrobe & opSignExt;
      uopSelA <= opStrobe ? opSelA : '0;
      uopSelS <= opStrobe ? opSelS : '0;
      uopSelT <= opStrobe ? opSelT : '0;
      uopFlagWr <= opStrobe & opFlagWr;
    end
  end

  colRowT colRowS, colRowU, colRowR, colRowWr;
  regIdxT wrIdxGated;
  regDataT rows [1:RegRowCnt-1];
  aluDataT operandS, operandU;
  wrBusIf wrBus ();

  assign wrIdxGated = regWrStrobe ? regWrIdx : '0; // Index 0 writes nothing

  colRowDecoder uColRowS (.regIdx(uopIdxS), .colRow(colRowS));
  colRowDecoder uColRowU (.regIdx(uopIdxU), .colRow(colRowU));
  colRowDecoder uColRowR (.regIdx(uopIdxR), .colRow(colRowR));
  colRowDecoder uColRowWr (.regIdx(wrIdxGated), .colRow(colRowWr));

  // Width field of S also sizes the constant
  operandMux uMuxS (
    .rows(rows), .colRow(colRowS), .ww(uopIdxS[5:4]), .signExt(uopSignExt),
    .constSel(uopConstSel), .constData(uopConst), .operand(operandS)
  );

  operandMux uMuxU (
    .rows(rows), .colRow(colRowU), .ww(uopIdxU[5:4]), .signExt(uopSignExt),
    .constSel(1'b0), .constData('0), .operand(operandU)
  );

  fastAlu uAluFast (
    .operandS(operandS), .operandU(operandU), .wwS(uopIdxS[5:4]), .wwU(uopIdxU[5:4]),
    .selA(uopSelA), .selS(uopSelS), .selT(uopSelT), .dstColRow(colRowR),
    .flagWr(uopFlagWr), .wrBus(wrBus.src)
  );

  regTask uRegTask (
    .clkH(clkH), .rstN(rstN), .wrBus(wrBus.dst), .extColRow(colRowWr),
    .extData(regWrData), .rdRow(regRdRow), .rows(rows), .rdData(regRdData),
    .flags(flags)
  );

  condAnalyzer uCond (.cond(condCode), .flagsIn(flags), .jmpEn(jmpEn));

endmodule

`default_nettype wire

// File: tb/execCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreTb;
  import cpuRegPkg::*;
  import cpuAluPkg::*;

  localparam int OpAdd = 0, OpSub = 1, OpAnd = 2, OpXor = 3, OpOr = 4, OpShl = 5;
  localparam int OpShr = 6, OpRol = 7, OpAsr = 8, OpBt = 9, OpBtr = 10, OpBts = 11;

  // Cycle budget of each test for the watchdog
  localparam int Cycles = 8 + 30 + 100 + 130 + 50 + 30 + 120;
  localparam int Timeout = (Cycles + 200) * 40;

  logic clkH, rstN, opStrobe, opConstSel, opSignExt, opFlagWr, regWrStrobe;
  regIdxT opIdxS, opIdxU, opIdxR, regWrIdx;
  aluDataT opConst;
  aluSelT opSelA, opSelS, opSelT;
  regDataT regWrData, regRdData;
  logic [2:0] regRdRow;
  flagsT flags;
  condT condCode;
  logic jmpEn;

  logic [63:0] mRows [0:7]; // Reference rows with row 0 kept at zero
  logic [3:0] mFlags;       // Reference VNZC
  logic [31:0] rngState;
  int errCnt, errAtStart, testPass, testFail;

  execCore uut (.*);

  initial clkH = 1'b0;
  always #20 clkH = ~clkH;

  initial begin
    #(Timeout);
    $display("Timeout: the tests did not finish within the expected time");
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic logic [2:0] randRow(); // Rows 1 to 7
    logic [31:0] v;
    v = nextRand();
    return 3'(v % 7 + 1);
  endfunction

  function automatic logic [63:0] sliceMask(logic [2:0] code);
    case (code)
      3'd0: return 64'h0000_0000_0000_00FF;
      3'd1: return 64'h0000_0000_0000_FF00;
      3'd2: return 64'h0000_0000_0000_FFFF;
      3'd3: return 64'h0000_0000_FFFF_0000;
      3'd4: return 64'h0000_0000_FFFF_FFFF;
      3'd5: return 64'hFFFF_FFFF_0000_0000;
      3'd6: return 64'hFFFF_FFFF_FFFF_FFFF;
      default: return 64'h0;
    endcase
  endfunction

  function automatic logic condRef(logic [3:0] c, logic [3:0] f);
    logic v, n, z, cy;
    {v, n, z, cy} = f;
    case (c)
      4'd0: return 1'b1;
      4'd1: return z | cy;
      4'd2: return cy;
      4'd3: return !cy;
      4'd4: return z;
      4'd5: return !z;
      4'd6: return !z && !cy;
      4'd7: return 1'b0;
      4'd8: return !z && (n == v);
      4'd9: return z || (n == v);
      4'd10: return n != v;
      4'd11: return z || (n != v);
      4'd12: return n;
      4'd13: return v;
      4'd14: return !n;
      default: return !v;
    endcase
  endfunction

  // Expected 32-bit result and VNZC of one op
  task automatic refOp(input int kind, input logic [31:0] s, input logic [31:0] u,
                       output logic [31:0] r, output logic [3:0] f);
    logic [32:0] sum;
    logic [4:0] a;
    logic c, v;
    a = s[4:0];
    c = 1'b0;
    v = 1'b0;
    r = '0;
    case (kind)
      OpAdd: begin
        sum = {1'b0, u} + {1'b0, s};
        r = sum[31:0];
        c = sum[32];
        v = (u[31] == s[31]) && (r[31] != u[31]);
      end
      OpSub: begin
        r = u - s;
        c = u < s;
        v = (u[31] != s[31]) && (r[31] != u[31]);
      end
      OpAnd: r = u & s;
      OpXor: r = u ^ s;
      OpOr: r = u | s;
      OpShl: begin
        r = u << a;
        c = (a != 0) && u[6'd32 - a];
      end
      OpShr: begin
        r = u >> a;
        c = (a != 0) && u[a - 5'd1];
      end
      OpAsr: begin
        r = $unsigned($signed(u) >>> a);
        c = (a != 0) && u[a - 5'd1];
      end
      OpRol: begin
        r = (a == 0) ? u : ((u << a) | (u >> (6'd32 - a)));
        c = (a != 0) && u[6'd32 - a];
      end
      OpBts: r = u | (32'h1 << a);
      OpBtr: r = u & ~(32'h1 << a);
      default: r = u; // bt
    endcase
    if (kind >= OpBt) f = {3'b000, u[a]};
    else f = {v, r[31], r == 32'h0, c};
  endtask

  task automatic tick();
    @(posedge clkH);
    #2;
  endtask

  task automatic clearOp();
    opStrobe = 1'b0;
    opIdxS = '0;
    opIdxU = '0;
    opIdxR = '0;
    opConst = '0;
    opConstSel = 1'b0;
    opSignExt = 1'b0;
    opSelA = '0;
    opSelS = '0;
    opSelT = '0;
    opFlagWr = 1'b0;
  endtask

  task automatic checkVal(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else begin
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
      errCnt++;
    end
  endtask

  task automatic checkState();
    for (int r = 0; r < 8; r++) begin
      regRdRow = 3'(r);
      #1;
      checkVal($sformatf("regRdData[%0d]", r), mRows[r], regRdData);
    end
    checkVal("flags", 64'(mFlags), 64'(flags));
  endtask

  task automatic extWrite(input logic [2:0] code, input logic [2:0] row, input logic [63:0] d);
    logic [63:0] m;
    regWrStrobe = 1'b1;
    regWrIdx = {code, row};
    regWrData = d;
    tick();
    regWrStrobe = 1'b0;
    m = sliceMask(code);
    if (row != 0) mRows[row] = (mRows[row] & ~m) | (d & m);
  endtask

  // Drives one strobe with a known S operand into a low 32-bit destination and updates the model
  task automatic issueRaw(input int kind, input regIdxT idxS, input logic [2:0] ru,
                          input logic [2:0] rd, input logic [31:0] cv, input logic cs,
                          input logic se, input logic fw, input logic [31:0] s);
    logic [31:0] r;
    logic [3:0] f;
    refOp(kind, s, mRows[ru][31:0], r, f);
    opIdxS = idxS;
    opIdxU = {3'd4, ru};
    opIdxR = {3'd4, rd};
    opConst = cv;
    opConstSel = cs;
    opSignExt = se;
    opFlagWr = fw;
    opSelA = '0;
    opSelS = '0;
    opSelT = '0;
    case (kind)
      OpAdd: opSelA = 4'b0001;
      OpSub: opSelA = 4'b0010;
      OpAnd: opSelA = 4'b0100;
      OpXor: opSelA = 4'b1000;
      OpOr: opSelA = 4'b1100;
      OpShl: opSelS = 4'b0001;
      OpShr: opSelS = 4'b0010;
      OpRol: opSelS = 4'b0100;
      OpAsr: opSelS = 4'b1000;
      OpBt: opSelT = 4'b0001;
      OpBtr: opSelT = 4'b0010;
      default: opSelT = 4'b0100;
    endcase
    opStrobe = 1'b1;
    tick(); // Capture edge
    if (rd != 0) mRows[rd][31:0] = r;
    if (fw) mFlags = f;
  endtask

  task automatic issueOp(input int kind, input logic [2:0] rs, input logic [2:0] ru,
                         input logic [2:0] rd, input logic fw);
    issueRaw(kind, {3'd4, rs}, ru, rd, 32'h0, 1'b0, 1'b0, fw, mRows[rs][31:0]);
  endtask

  task automatic writeBackCheck();
    clearOp();
    tick(); // Write edge
    checkState();
  endtask

  task automatic runOp(input int kind, input logic [2:0] rs, input logic [2:0] ru,
                       input logic [2:0] rd, input logic fw);
    issueOp(kind, rs, ru, rd, fw);
    writeBackCheck();
  endtask

  task automatic finishTest(input string name);
    if (errCnt == errAtStart) begin
      testPass++;
      $display("Test %s: ok", name);
    end else begin
      testFail++;
      $display("Test %s: %0d errors", name, errCnt - errAtStart);
    end
    errAtStart = errCnt;
  endtask

  initial begin
    logic [7:0] b;
    logic [31:0] cv;
    rngState = 32'd65546;
    errCnt = 0;
    errAtStart = 0;
    testPass = 0;
    testFail = 0;
    for (int r = 0; r < 8; r++) mRows[r] = '0;
    mFlags = '0;
    rstN = 1'b0;
    clearOp();
    regWrStrobe = 1'b0;
    regWrIdx = '0;
    regWrData = '0;
    regRdRow = '0;
    condCode = '0;
    repeat (8) @(posedge clkH);
    #2;
    rstN = 1'b1;

    // ******************************************************************
    // External slice writes
    // ******************************************************************
    checkState();
    for (int code = 0; code < 8; code++) begin
      extWrite(3'(code), randRow(), {nextRand(), nextRand()});
      checkState();
    end
    extWrite(3'd6, 3'd0, {nextRand(), nextRand()});
    checkState();
    finishTest("reset and slice writes");

    for (int r = 1; r < 8; r++) extWrite(3'd6, 3'(r), {nextRand(), nextRand()});
    for (int i = 0; i < 40; i++) begin
      runOp(OpAdd + int'(nextRand() % 5), randRow(), randRow(), randRow(), 1'b1);
    end
    finishTest("arithmetic and logic");

    for (int i = 0; i < 56; i++) begin
      runOp(OpShl + int'(nextRand() % 7), randRow(), randRow(), randRow(), (i % 4) != 3);
    end
    finishTest("shifts and bit ops");

    // ******************************************************************
    // Byte operands and constants without flag writes
    // ******************************************************************
    for (int i = 0; i < 4; i++) begin
      logic [2:0] rb;
      rb = randRow();
      extWrite(3'd0, rb, 64'(nextRand() | 32'h80)); // Byte sign bit set
      b = mRows[rb][7:0];
      issueRaw(OpAdd, {3'd0, rb}, randRow(), randRow(), 32'h0, 1'b0, i[0], 1'b0,
               i[0] ? {{24{b[7]}}, b} : {24'h0, b});
      writeBackCheck();
      rb = randRow();
      extWrite(3'd1, rb, 64'(nextRand() | 32'h8000));
      b = mRows[rb][15:8];
      issueRaw(OpAdd, {3'd1, rb}, randRow(), randRow(), 32'h0, 1'b0, i[0], 1'b0,
               i[0] ? {{24{b[7]}}, b} : {24'h0, b});
      writeBackCheck();
      cv = nextRand() | 32'h80;
      issueRaw(OpAdd, 6'd0, randRow(), randRow(), cv, 1'b1, i[0], 1'b0,
               i[0] ? {{24{cv[7]}}, cv[7:0]} : {24'h0, cv[7:0]});
      writeBackCheck();
      cv = nextRand();
      issueRaw(OpSub, 6'b100_000, randRow(), randRow(), cv, 1'b1, 1'b0, 1'b0, cv);
      writeBackCheck();
    end
    finishTest("operand widths and constants");

    for (int i = 0; i < 8; i++) begin
      issueOp(OpAdd + int'(nextRand() % 4), randRow(), 3'(i % 7 + 1), 3'((i + 1) % 7 + 1),
              1'b1);
    end
    writeBackCheck();
    finishTest("back-to-back ops");

    for (int c = 0; c < 16; c++) begin
      for (int j = 0; j < 3; j++) begin
        logic [2:0] rr;
        rr = randRow();
        if (j == 0) runOp(OpSub, rr, rr, randRow(), 1'b1); // Equal operands give Z
        else runOp(OpAdd + int'(nextRand() % 2), randRow(), randRow(), randRow(), 1'b1);
        condCode = 4'(c);
        #1;
        checkVal($sformatf("jmpEn cond %0d", c), 64'(condRef(4'(c), mFlags)), 64'(jmpEn));
      end
    end
    finishTest("conditions");

    $display("Tests passed %0d failed %0d, checks failed %0d", testPass, testFail, errCnt);
    if (errCnt == 0 && testFail == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
design/cpuRegPkg.sv
design/cpuAluPkg.sv
design/wrBusIf.sv
design/colRowDecoder.sv
design/regTask.sv
design/operandMux.sv
design/aluArith.sv
design/aluShift.sv
design/fastAlu.sv
design/condAnalyzer.sv
design/execCore.sv
tb/execCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= execCoreTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "No result in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
